// ==== rtl/fetch_params.svh ====
// fetch front end sizing macros shared by the packages and the stage modules
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address and memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ADDR_W 32          // byte address width of the fetch path

`define IMEM_WORDS 256     // instruction memory depth in 32-bit words

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flow control and start-up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// one credit per slot of the decode queue downstream
`define FETCH_CREDITS 4

`define RESET_PC 32'h0000_0000   // first address fetched once reset drops

`endif

// ==== rtl/isa_pkg.sv ====
// instruction encoding package with the word, opcode and immediate types
`default_nettype none

package isa_pkg;

  typedef logic [31:0] instr_t;  // one fetched instruction word

  typedef logic [31:0] imm_t;    // immediate after sign extension

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcodes of the base integer set
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,  // alu with immediate, used as filler in programs
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111   // the only control transfer seen by the front end
  } opcode_t;

  // opcode sits in the low seven bits of every format
  function automatic opcode_t opcode_of(input instr_t instr);
    return opcode_t'(instr[6:0]);
  endfunction

  // j-type immediate, scattered as imm[20|10:1|11|19:12] in bits 31:12
  function automatic imm_t j_imm(input instr_t instr);
    return {{11{instr[31]}},   // sign extension
            instr[31],         // imm[20]
            instr[19:12],      // imm[19:12]
            instr[20],         // imm[11]
            instr[30:21],      // imm[10:1]
            1'b0};             // targets are always halfword aligned
  endfunction

endpackage

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
// fetch path bookkeeping package with the address and credit counter types
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // addresses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [`ADDR_W-1:0] addr_t;  // byte address

  // sequential successor of a fetch address, one word further on
  function automatic addr_t seq_pc(input addr_t pc);
    return pc + addr_t'(4);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // credits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // wide enough for every count from zero up to the full credit pool
  localparam int CREDIT_W = $clog2(`FETCH_CREDITS + 1);

  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

// ==== rtl/pc_stage.sv ====
// program counter stage that picks the next fetch address and spends credits on issue
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module pc_stage
  import fetch_pkg::*;
  ( input  wire        clk
  , input  wire        reset
  , input  wire        redirect       // flush from a later pipeline stage
  , input  wire addr_t redirect_pc
  , input  wire        jump_valid     // taken jal seen in predecode this cycle
  , input  wire addr_t jump_target
  , input  wire        credit_return  // consumer freed one queue slot
  , input  wire        refund         // predecode dropped an in-flight word
  , output logic       issue_valid
  , output addr_t      issue_pc
  );

  addr_t   fetch_pc;      // address the next issue will use on the current path
  addr_t   next_pc;       // address chosen for this cycle
  credit_t credits;       // credits currently held by the front end
  credit_t credits_avail; // held credits plus everything coming back this cycle
  logic    flush_refund;
  logic    issue;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next address selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // redirect wins over a jal, and a jal wins over the sequential path
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (jump_valid) begin
      next_pc = jump_target;      // issued in place of the sequential word
    end else begin
      next_pc = fetch_pc;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // credit accounting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the memory stage drops the word on the issue bus when a redirect hits
  assign flush_refund = redirect & issue_valid;

  assign credits_avail = credits
                       + credit_t'(credit_return)
                       + credit_t'(refund)
                       + credit_t'(flush_refund);

  assign issue = (credits_avail != '0);  // a credit coming back can be spent at once

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_valid <= 1'b0;
      credits     <= credit_t'(`FETCH_CREDITS);  // the whole queue is free
      fetch_pc    <= addr_t'(`RESET_PC);
    end else begin
      issue_valid <= issue;
      credits     <= credits_avail - credit_t'(issue);
      // the pc only steps on an issue, otherwise it just parks on the chosen address
      if (issue) begin
        fetch_pc <= seq_pc(next_pc);
      end else begin
        fetch_pc <= next_pc;
      end
    end
  end

  // issued address goes out registered, next to issue_valid
  always_ff @(posedge clk) begin
    if (issue) begin
      issue_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/imem_stage.sv ====
// instruction memory stage with a load port and a registered read that carries the pc along
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module imem_stage
  import fetch_pkg::*, isa_pkg::*;
  ( input  wire         clk
  , input  wire         reset
  , input  wire         issue_valid
  , input  wire addr_t  issue_pc
  , input  wire         redirect    // kills the word being read this cycle
  , input  wire         load_en     // program load write strobe
  , input  wire addr_t  load_addr
  , input  wire instr_t load_data
  , output logic        rd_valid
  , output addr_t       rd_pc
  , output instr_t      rd_instr
  );

  localparam int IDX_W = $clog2(`IMEM_WORDS);

  instr_t           mem [`IMEM_WORDS];  // contents survive reset
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  // byte addresses down to word index
  assign rd_idx = issue_pc[IDX_W+1:2];
  assign wr_idx = load_addr[IDX_W+1:2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[wr_idx] <= load_data;
    end
  end

  // synchronous read, so data shows up one cycle after the issue
  always_ff @(posedge clk) begin
    rd_instr <= mem[rd_idx];
    rd_pc    <= issue_pc;  // pc rides along with its word
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= issue_valid & ~redirect;  // the pc stage refunds the dropped issue
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jal_predecode.sv ====
// predecode stage that spots jal, sends its target back and registers outgoing words
`timescale 1ns/100ps
`default_nettype none

module jal_predecode
  import fetch_pkg::*, isa_pkg::*;
  ( input  wire         clk
  , input  wire         reset
  , input  wire         rd_valid
  , input  wire addr_t  rd_pc
  , input  wire instr_t rd_instr
  , input  wire         redirect
  , output logic        jump_valid
  , output addr_t       jump_target
  , output logic        refund      // one credit back for a dropped word
  , output logic        out_valid
  , output addr_t       out_pc
  , output instr_t      out_instr
  );

  opcode_t opcode;
  imm_t    imm;
  logic    squash;  // the sequential word behind a taken jal arrives this cycle
  logic    drop;
  logic    keep;

  assign opcode = opcode_of(rd_instr);
  assign imm    = j_imm(rd_instr);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // squash and jump detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign drop = rd_valid & (squash | redirect);
  assign keep = rd_valid & ~drop;

  assign refund = drop;

  // a squashed jal is on the wrong path and must not steer fetch
  assign jump_valid  = keep & (opcode == OP_JAL);
  assign jump_target = rd_pc + addr_t'(imm);

  // the target is issued no earlier than the next cycle, so whatever reaches
  // this stage right after a jal can only be the stale sequential word
  always_ff @(posedge clk) begin
    if (reset) begin
      squash    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      squash    <= jump_valid;  // cleared again by the next word we take
      out_valid <= keep;
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      out_pc    <= rd_pc;
      out_instr <= rd_instr;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
// instruction fetch front end top that chains the pc, memory and predecode stages
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*, isa_pkg::*;
  ( input  wire         clk
  , input  wire         reset
  , input  wire         redirect
  , input  wire addr_t  redirect_pc
  , input  wire         credit_return
  , input  wire         load_en
  , input  wire addr_t  load_addr
  , input  wire instr_t load_data
  , output logic        out_valid
  , output addr_t       out_pc
  , output instr_t      out_instr
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage to stage wires
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic   issue_valid;
  addr_t  issue_pc;
  logic   rd_valid;
  addr_t  rd_pc;
  instr_t rd_instr;
  logic   jump_valid;   // feedback from predecode into next-pc selection
  addr_t  jump_target;
  logic   refund;

  pc_stage pc_stage_inst
    ( .clk           ( clk           )
    , .reset         ( reset         )
    , .redirect      ( redirect      )
    , .redirect_pc   ( redirect_pc   )
    , .jump_valid    ( jump_valid    )
    , .jump_target   ( jump_target   )
    , .credit_return ( credit_return )
    , .refund        ( refund        )
    , .issue_valid   ( issue_valid   )
    , .issue_pc      ( issue_pc      )
    );

  imem_stage imem_stage_inst
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .issue_valid ( issue_valid )
    , .issue_pc    ( issue_pc    )
    , .redirect    ( redirect    )
    , .load_en     ( load_en     )
    , .load_addr   ( load_addr   )
    , .load_data   ( load_data   )
    , .rd_valid    ( rd_valid    )
    , .rd_pc       ( rd_pc       )
    , .rd_instr    ( rd_instr    )
    );

  jal_predecode jal_predecode_inst
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .rd_valid    ( rd_valid    )
    , .rd_pc       ( rd_pc       )
    , .rd_instr    ( rd_instr    )
    , .redirect    ( redirect    )
    , .jump_valid  ( jump_valid  )
    , .jump_target ( jump_target )
    , .refund      ( refund      )
    , .out_valid   ( out_valid   )
    , .out_pc      ( out_pc      )
    , .out_instr   ( out_instr   )
    );

endmodule

`default_nettype wire

// ==== test/fetch_unit_sva.sv ====
// concurrent checks on reset, redirect flushing and the credit bound of the fetch front end
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit_sva
  ( input wire clk
  , input wire reset
  , input wire redirect
  , input wire credit_return
  , input wire out_valid
  );

  logic [7:0] owed;  // delivered words the consumer has not handed back yet

  always_ff @(posedge clk) begin
    if (reset) begin
      owed <= '0;
    end else begin
      owed <= owed + 8'(out_valid) - 8'(credit_return);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // output stays quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !out_valid)
    else $error("output valid while reset is held");

  // the downstream queue can never be overfilled
  credit_bound: assert property (@(posedge clk) disable iff (reset)
    (owed + 8'(out_valid)) <= 8'(`FETCH_CREDITS))
    else $error("more words outstanding than credits");

  // nothing from the old path leaves right after a redirect
  flush_after_redirect: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !out_valid)
    else $error("stale word delivered after redirect");

endmodule

bind fetch_unit fetch_unit_sva fetch_unit_sva_inst
  ( .clk           ( clk           )
  , .reset         ( reset         )
  , .redirect      ( redirect      )
  , .credit_return ( credit_return )
  , .out_valid     ( out_valid     )
  );

`default_nettype wire

// ==== test/fetch_unit_tb.sv ====
// testbench for the fetch front end with program load, credit consumer and reference model
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit_tb
  import fetch_pkg::*, isa_pkg::*;
  ();

  logic   clk;
  logic   reset;
  logic   redirect;
  addr_t  redirect_pc;
  logic   credit_return;
  logic   load_en;
  addr_t  load_addr;
  instr_t load_data;
  logic   out_valid;
  addr_t  out_pc;
  instr_t out_instr;

  instr_t      prog [`IMEM_WORDS];  // copy of what was loaded
  addr_t       step [`IMEM_WORDS];  // how far each loaded word moves the fetch pc
  logic [31:0] rng_state;
  addr_t       exp_pc;              // next pc the model expects to see
  addr_t       first_pc;
  addr_t       redir_target;
  logic        redir_pending;
  logic        withhold;            // consumer keeps its credits
  int          owed;
  int          delay;
  int          delivered;
  int          jals_seen;
  int          checks;
  int          errors;

  fetch_unit fetch_unit_inst
    ( .clk           ( clk           )
    , .reset         ( reset         )
    , .redirect      ( redirect      )
    , .redirect_pc   ( redirect_pc   )
    , .credit_return ( credit_return )
    , .load_en       ( load_en       )
    , .load_addr     ( load_addr     )
    , .load_data     ( load_data     )
    , .out_valid     ( out_valid     )
    , .out_pc        ( out_pc        )
    , .out_instr     ( out_instr     )
    );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // j-type layout puts imm[20|10:1|11|19:12] in bits 31:12, rd is x1
  function automatic instr_t make_jal(input logic [20:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd1, 7'b1101111};
  endfunction

  // one clock: check the output, then drive the consumer and any redirect
  task automatic tick();
    instr_t     w;
    logic [7:0] idx;
    @(negedge clk);
    if (out_valid) begin
      idx = exp_pc[9:2];
      w = prog[idx];
      checks = checks + 2;
      assert (out_pc == exp_pc) else begin
        errors++;
        $display("Fail out_pc: got %h expected %h", out_pc, exp_pc);
      end
      assert (out_instr == w) else begin
        errors++;
        $display("Fail out_instr: got %h expected %h at pc %h", out_instr, w, exp_pc);
      end
      if (delivered == 0) first_pc = out_pc;
      if (w[6:0] == 7'b1101111) jals_seen++;
      exp_pc = exp_pc + step[idx];
      delivered++;
      owed++;
    end
    credit_return = 1'b0;
    if (!withhold && owed > 0) begin
      if (delay == 0) begin
        credit_return = 1'b1;
        owed--;
        rng_state = xorshift(rng_state);
        delay = int'(rng_state % 4);  // random consumer latency
      end else begin
        delay--;
      end
    end
    redirect = redir_pending;
    redirect_pc = redir_target;
    if (redir_pending) exp_pc = redir_target;  // the model restarts here
    redir_pending = 1'b0;
  endtask

  task automatic wait_words(input int n);
    int target;
    int cycles;
    target = delivered + n;
    cycles = 0;
    while (delivered < target) begin
      if (cycles >= n * 30 + 60) begin
        $display("Timeout: only %0d of %0d words arrived", n - (target - delivered), n);
        $display("Done: errors found");
        $finish;
      end
      tick();
      cycles++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int e0;
    int stalled_at;
    int jump;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    credit_return = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    rng_state = 32'd26495;
    exp_pc = addr_t'(`RESET_PC);
    first_pc = '1;
    redir_target = '0;
    redir_pending = 1'b0;
    withhold = 1'b0;
    owed = 0;
    delay = 0;
    delivered = 0;
    jals_seen = 0;
    checks = 0;
    errors = 0;

    // lower half is straight-line filler, upper half mixes in short forward jals
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      rng_state = xorshift(rng_state);
      if (i >= 128 && i < 250 && rng_state % 6 == 0) begin
        jump = 8 + 4 * int'((rng_state >> 8) % 4);
        prog[i] = make_jal(21'(jump));
        step[i] = addr_t'(jump);
      end else begin
        prog[i] = {rng_state[31:7], OP_IMM};
        step[i] = addr_t'(4);
      end
      @(negedge clk);
      load_en = 1'b1;
      load_addr = addr_t'(i * 4);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    e0 = errors;
    wait_words(1);
    checks++;
    assert (first_pc == addr_t'(`RESET_PC)) else begin
      errors++;
      $display("Fail out_pc: first word %h expected %h", first_pc, addr_t'(`RESET_PC));
    end
    report("reset", e0);

    e0 = errors;
    wait_words(24);
    report("sequential", e0);

    e0 = errors;
    redir_target = addr_t'(128 * 4);
    redir_pending = 1'b1;
    wait_words(50);
    checks++;
    assert (jals_seen > 0) else begin
      errors++;
      $display("No jal was delivered on the jump test path");
    end
    report("jal", e0);

    e0 = errors;
    withhold = 1'b1;
    repeat (30) tick();
    stalled_at = delivered;
    repeat (15) tick();
    checks = checks + 2;
    assert (delivered == stalled_at) else begin
      errors++;
      $display("Output kept flowing with all credits withheld");
    end
    assert (owed <= `FETCH_CREDITS) else begin
      errors++;
      $display("Fail owed: got %h limit %h", owed, `FETCH_CREDITS);
    end
    withhold = 1'b0;
    wait_words(12);
    report("credits", e0);

    e0 = errors;
    rng_state = xorshift(rng_state);
    redir_target = addr_t'((128 + rng_state % 100) * 4);
    redir_pending = 1'b1;
    wait_words(30);
    report("redirect", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/pc_stage.sv
rtl/imem_stage.sv
rtl/jal_predecode.sv
rtl/fetch_unit.sv
test/fetch_unit_sva.sv
test/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the fetch_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f fetch_unit.f \
  --top-module fetch_unit_tb -o fetch_unit_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/fetch_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
